// ==== flist.f ====
source/mem_stage_pkg.sv
source/mem_access_fsm.sv
source/bus_timer.sv
source/amo_alu.sv
source/mem_lane_align.sv
source/data_ram.sv
source/mem_stage_top.sv
tb/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - source/mem_stage_pkg.sv
      - source/mem_access_fsm.sv
      - source/bus_timer.sv
      - source/amo_alu.sv
      - source/mem_lane_align.sv
      - source/data_ram.sv
      - source/mem_stage_top.sv
  - target: test
    files:
      - tb/tb_mem_stage.sv

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/1ps

module tb_mem_stage import mem_stage_pkg::*; ();

    localparam int n_init     = 32;     // words written before any load
    localparam int n_loads    = 40;
    localparam int n_stores   = 40;
    localparam int n_pairs    = 20;     // 16 boundary pairs, then random ones
    localparam int n_resv     = 8;
    localparam int n_unmapped = 6;
    localparam int n_dup      = 4;
    localparam int n_ops      = n_init + n_loads + 2 * n_stores + 27 * n_pairs
                              + 8 * n_resv + 2 * n_unmapped + 5 * n_dup;
    localparam int wd_cycles  = n_ops * (bus_timeout + 8) + 10;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    req_id_t   req_id;
    mem_kind_e req_kind;
    mem_func_u req_func;
    addr_t     req_addr;
    data_t     req_wdata;
    logic      stall;
    data_t     rsp_rdata;
    logic      rsp_fault;

    logic [31:0] lfsr;
    logic [7:0]  model_mem [ram_bytes];
    addr_t       resv_addr;
    logic        resv_vld;
    req_id_t     last_id;
    logic        last_vld;
    data_t       last_rdata;
    logic        last_fault;
    data_t       bounds [4] = '{32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};

    mem_stage_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_id    (req_id),
        .req_kind  (req_kind),
        .req_func  (req_func),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .stall     (stall),
        .rsp_rdata (rsp_rdata),
        .rsp_fault (rsp_fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // aligned address inside the initialized words
    function automatic addr_t region_addr(input mem_size_e size);
        addr_t a;
        a = addr_t'(rand_bits(5)) << 2;
        if (size == size_b) begin
            a[1:0] = 2'(rand_bits(2));
        end else if (size == size_h) begin
            a[1] = 1'(rand_bits(1));
        end
        return a;
    endfunction

    function automatic mem_func_u plain_func(input logic zext, input mem_size_e size);
        mem_func_u f;
        f.plain.zext  = zext;
        f.plain.size  = size;
        f.plain.spare = 1'b0;
        return f;
    endfunction

    function automatic mem_func_u atomic_func(input amo_op_e op);
        mem_func_u f;
        f.atomic = op;
        return f;
    endfunction

    function automatic data_t model_word(input addr_t addr);
        addr_t b;
        b = addr & ~addr_t'(3);
        return {model_mem[b + 3], model_mem[b + 2], model_mem[b + 1], model_mem[b]};
    endfunction

    function automatic data_t model_load(input addr_t addr, input mem_size_e size, input logic zext);
        logic [7:0]  b;
        logic [15:0] h;
        b = model_mem[addr];
        h = {model_mem[addr + 1], model_mem[addr]};
        case (size)
            size_b:  return zext ? {24'h0, b} : {{24{b[7]}}, b};
            size_h:  return zext ? {16'h0, h} : {{16{h[15]}}, h};
            default: return model_word(addr);
        endcase
    endfunction

    function automatic data_t amo_result(input amo_op_e op, input data_t old, input data_t opd);
        case (op)
            amo_swap: return opd;
            amo_add:  return old + opd;
            amo_xor:  return old ^ opd;
            amo_and:  return old & opd;
            amo_or:   return old | opd;
            amo_min:  return ($signed(old) <= $signed(opd)) ? old : opd;
            amo_max:  return ($signed(old) >= $signed(opd)) ? old : opd;
            amo_minu: return (old <= opd) ? old : opd;
            default:  return (old >= opd) ? old : opd;     // maxu
        endcase
    endfunction

    task automatic write_word(input addr_t addr, input data_t w);
        for (int i = 0; i < 4; i++) begin
            model_mem[addr + i] = w[8*i +: 8];
        end
    endtask

    task automatic model_exec(input mem_kind_e kind, input mem_func_u func, input addr_t addr,
                              input data_t wdata, output data_t rdata, output logic fault);
        int nbytes;
        rdata = '0;
        fault = 1'b0;
        if (addr >= addr_t'(ram_bytes)) begin
            fault = 1'b1;                               // nobody answers, timer fires
        end else if (kind == kind_load) begin
            rdata = model_load(addr, func.plain.size, func.plain.zext);
        end else if (kind == kind_store) begin
            nbytes = 1 << func.plain.size;
            for (int i = 0; i < nbytes; i++) begin
                model_mem[addr + i] = wdata[8*i +: 8];
            end
        end else if (func.atomic == amo_lr) begin
            rdata     = model_word(addr);
            resv_addr = addr;
            resv_vld  = 1'b1;
        end else if (func.atomic == amo_sc) begin
            rdata = data_t'(!(resv_vld && resv_addr == addr));
            if (rdata == '0) begin
                write_word(addr, wdata);
            end
            resv_vld = 1'b0;
        end else begin
            rdata = model_word(addr);
            write_word(addr, amo_result(func.atomic, rdata, wdata));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_fault(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "flag mismatch");
        end
    endtask

    // called on a falling edge, returns on the falling edge of the completion cycle
    task automatic issue(input mem_kind_e kind, input mem_func_u func, input addr_t addr,
                         input data_t wdata, input logic same_id);
        data_t exp_rdata;
        logic  exp_fault;
        if (!same_id) begin
            req_id = req_id + 1'b1;
        end
        req_valid = 1'b1;
        req_kind  = kind;
        req_func  = func;
        req_addr  = addr;
        req_wdata = wdata;
        if (last_vld && req_id == last_id) begin
            exp_rdata = last_rdata;                     // repeat, held result only
            exp_fault = last_fault;
            @(negedge clk);
            check_fault("stall", stall, 1'b0);
        end else begin
            model_exec(kind, func, addr, wdata, exp_rdata, exp_fault);
            last_id    = req_id;
            last_vld   = 1'b1;
            last_rdata = exp_rdata;
            last_fault = exp_fault;
            do begin
                @(negedge clk);
            end while (stall);
        end
        check_data("rsp_rdata", rsp_rdata, exp_rdata);
        check_fault("rsp_fault", rsp_fault, exp_fault);
    endtask

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("[TIMEOUT] no completion within %0d cycles, the memory stage looks hung",
                 wd_cycles);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        mem_kind_e kind;
        mem_size_e size;
        addr_t     a;
        addr_t     a2;
        data_t     opd;
        lfsr       = 32'hf2c29c94;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_id     = '0;
        req_kind   = kind_none;
        req_func   = '0;
        req_addr   = '0;
        req_wdata  = '0;
        resv_addr  = '0;
        resv_vld   = 1'b0;
        last_id    = '0;
        last_vld   = 1'b0;
        last_rdata = '0;
        last_fault = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_fault("stall", stall, 1'b0);
        check_fault("rsp_fault", rsp_fault, 1'b0);

        for (int i = 0; i < n_init; i++) begin
            issue(kind_store, plain_func(1'b0, size_w), addr_t'(i * 4), rand_bits(32), 1'b0);
        end

        // loads of all sizes, signed and unsigned
        for (int i = 0; i < n_loads; i++) begin
            size = mem_size_e'(2'(rand_bits(2) % 3));
            a    = region_addr(size);
            issue(kind_load, plain_func(1'(rand_bits(1)), size), a, '0, 1'b0);
        end

        for (int i = 0; i < n_stores; i++) begin
            size = mem_size_e'(2'(rand_bits(2) % 3));
            a    = region_addr(size);
            issue(kind_store, plain_func(1'b0, size), a, rand_bits(32), 1'b0);
            issue(kind_load, plain_func(1'b0, size_w), a & ~addr_t'(3), '0, 1'b0);
        end

        // every AMO op, old word and operand over the boundary set first
        for (int o = 2; o <= 10; o++) begin
            for (int p = 0; p < n_pairs; p++) begin
                a   = region_addr(size_w);
                opd = (p < 16) ? bounds[p / 4] : rand_bits(32);
                issue(kind_store, plain_func(1'b0, size_w), a, opd, 1'b0);
                opd = (p < 16) ? bounds[p % 4] : rand_bits(32);
                issue(kind_atomic, atomic_func(amo_op_e'(4'(o))), a, opd, 1'b0);
                issue(kind_load, plain_func(1'b0, size_w), a, '0, 1'b0);
            end
        end

        for (int i = 0; i < n_resv; i++) begin
            a  = region_addr(size_w);
            a2 = a ^ addr_t'(4);                            // neighbour word
            issue(kind_atomic, atomic_func(amo_lr), a, '0, 1'b0);
            issue(kind_atomic, atomic_func(amo_sc), a, rand_bits(32), 1'b0);
            issue(kind_atomic, atomic_func(amo_sc), a, rand_bits(32), 1'b0);
            issue(kind_load, plain_func(1'b0, size_w), a, '0, 1'b0);
            issue(kind_atomic, atomic_func(amo_lr), a, '0, 1'b0);
            issue(kind_atomic, atomic_func(amo_sc), a2, rand_bits(32), 1'b0);
            issue(kind_load, plain_func(1'b0, size_w), a2, '0, 1'b0);
            issue(kind_atomic, atomic_func(amo_sc), a, rand_bits(32), 1'b0);
        end

        for (int i = 0; i < n_unmapped; i++) begin
            a    = addr_t'(ram_bytes) + (addr_t'(rand_bits(8)) << 2);
            kind = mem_kind_e'(2'(1 + i % 3));
            issue(kind, (kind == kind_atomic) ? atomic_func(amo_add) : plain_func(1'b0, size_w),
                  a, rand_bits(32), 1'b0);
            issue(kind_load, plain_func(1'b0, size_w), region_addr(size_w), '0, 1'b0);
        end

        // same id held valid, memory must change once
        for (int i = 0; i < n_dup; i++) begin
            a   = region_addr(size_w);
            opd = rand_bits(32);
            issue(kind_atomic, atomic_func(amo_add), a, opd, 1'b0);
            repeat (3) issue(kind_atomic, atomic_func(amo_add), a, opd, 1'b1);
            issue(kind_load, plain_func(1'b0, size_w), a, '0, 1'b0);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== source/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  req_id_t   req_id,
    input  mem_kind_e req_kind,
    input  mem_func_u req_func,
    input  addr_t     req_addr,
    input  data_t     req_wdata,
    output logic      stall,
    output data_t     rsp_rdata,
    output logic      rsp_fault
);

    // wishbone
    logic             cyc;
    logic             stb;
    logic             we;
    logic             ack;
    logic [sel_w-1:0] sel;
    data_t            dat_w;
    data_t            dat_r;

    logic  capture;
    logic  clear;
    logic  sc_fail;
    logic  expired;
    data_t saved_word;
    data_t amo_word;

    mem_access_fsm i_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_id    (req_id),
        .req_kind  (req_kind),
        .req_func  (req_func),
        .req_addr  (req_addr),
        .ack       (ack),
        .expired   (expired),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .capture   (capture),
        .clear     (clear),
        .sc_fail   (sc_fail),
        .stall     (stall),
        .rsp_fault (rsp_fault)
    );

    bus_timer i_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (stb && !ack),     // waiting on the slave
        .expired (expired)
    );

    amo_alu i_amo (
        .op       (req_func.atomic),
        .old_word (saved_word),
        .operand  (req_wdata),
        .new_word (amo_word)
    );

    mem_lane_align i_align (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .clear      (clear),
        .sc_fail    (sc_fail),
        .req_kind   (req_kind),
        .req_func   (req_func),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .amo_word   (amo_word),
        .dat_r      (dat_r),
        .sel        (sel),
        .dat_w      (dat_w),
        .saved_word (saved_word),
        .rsp_rdata  (rsp_rdata)
    );

    data_ram i_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .sel   (sel),
        .adr   (req_addr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ps

module data_ram import mem_stage_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [sel_w-1:0] sel,
    input  addr_t            adr,
    input  data_t            dat_w,
    output data_t            dat_r,
    output logic             ack
);

    data_t mem [ram_words];

    logic [wait_w-1:0] wait_cnt;
    logic [ram_aw-1:0] word_idx;
    logic              mapped;
    logic              active;
    logic              fire;

    assign mapped   = adr < addr_t'(ram_bytes);   // unmapped never acks
    assign word_idx = adr[ram_aw+1:2];
    assign active   = cyc && stb && mapped && !ack;
    assign fire     = active && wait_cnt == wait_w'(ram_wait - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            ack      <= 1'b0;
        end else begin
            ack <= fire;
            if (active && !fire) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (we) begin
                for (int i = 0; i < sel_w; i++) begin
                    if (sel[i]) begin
                        mem[word_idx][8*i +: 8] <= dat_w[8*i +: 8];
                    end
                end
            end else begin
                dat_r <= mem[word_idx];
            end
        end
    end

endmodule

// ==== source/mem_lane_align.sv ====
`timescale 1ns/1ps

module mem_lane_align import mem_stage_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             capture,
    input  logic             clear,
    input  logic             sc_fail,
    input  mem_kind_e        req_kind,
    input  mem_func_u        req_func,
    input  addr_t            req_addr,
    input  data_t            req_wdata,
    input  data_t            amo_word,
    input  data_t            dat_r,
    output logic [sel_w-1:0] sel,
    output data_t            dat_w,
    output data_t            saved_word,
    output data_t            rsp_rdata
);

    logic  is_atomic;
    logic  is_sc;
    data_t lane;

    assign is_atomic = req_kind == kind_atomic;
    assign is_sc     = is_atomic && req_func.atomic == amo_sc;
    assign lane      = saved_word >> {req_addr[1:0], 3'b000};  // addressed byte to bit 0

    // store steering
    always_comb begin
        sel   = '1;
        dat_w = req_wdata;
        if (is_atomic) begin
            if (!is_sc) begin
                dat_w = amo_word;
            end
        end else begin
            case (req_func.plain.size)
                size_b: begin
                    sel   = sel_w'(1) << req_addr[1:0];
                    dat_w = {4{req_wdata[7:0]}};
                end
                size_h: begin
                    sel   = sel_w'(3) << {req_addr[1], 1'b0};
                    dat_w = {2{req_wdata[15:0]}};
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saved_word <= '0;
        end else if (clear) begin
            saved_word <= '0;       // timed out
        end else if (capture) begin
            saved_word <= dat_r;
        end
    end

    always_comb begin
        case (req_kind)
            kind_load: begin
                case (req_func.plain.size)
                    size_b:  rsp_rdata = req_func.plain.zext ? {24'b0, lane[7:0]}
                                                             : {{24{lane[7]}}, lane[7:0]};
                    size_h:  rsp_rdata = req_func.plain.zext ? {16'b0, lane[15:0]}
                                                             : {{16{lane[15]}}, lane[15:0]};
                    default: rsp_rdata = saved_word;
                endcase
            end
            kind_atomic: rsp_rdata = is_sc ? data_t'(sc_fail) : saved_word;
            kind_store:  rsp_rdata = '0;
            default:     rsp_rdata = saved_word;
        endcase
    end

endmodule

// ==== source/amo_alu.sv ====
`timescale 1ns/1ps

module amo_alu import mem_stage_pkg::*; (
    input  amo_op_e op,
    input  data_t   old_word,
    input  data_t   operand,
    output data_t   new_word
);

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(old_word) < $signed(operand);
    assign lt_u = old_word < operand;

    always_comb begin
        case (op)
            amo_swap: new_word = operand;
            amo_add:  new_word = old_word + operand;
            amo_xor:  new_word = old_word ^ operand;
            amo_and:  new_word = old_word & operand;
            amo_or:   new_word = old_word | operand;
            amo_min:  new_word = lt_s ? old_word : operand;
            amo_max:  new_word = lt_s ? operand : old_word;
            amo_minu: new_word = lt_u ? old_word : operand;
            amo_maxu: new_word = lt_u ? operand : old_word;
            default:  new_word = operand;   // lr/sc, not written from here
        endcase
    end

endmodule

// ==== source/bus_timer.sv ====
`timescale 1ns/1ps

module bus_timer import mem_stage_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic expired
);

    logic [timer_w-1:0] cnt;

    // fires in the bus_timeout-th cycle of run
    assign expired = run && cnt == timer_w'(bus_timeout - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;
        end else if (!expired) begin
            cnt <= cnt + 1'b1;
        end
        // else hold, saturated
    end

endmodule

// ==== source/mem_access_fsm.sv ====
`timescale 1ns/1ps

module mem_access_fsm import mem_stage_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  req_id_t   req_id,
    input  mem_kind_e req_kind,
    input  mem_func_u req_func,
    input  addr_t     req_addr,
    input  logic      ack,
    input  logic      expired,
    output logic      cyc,
    output logic      stb,
    output logic      we,
    output logic      capture,
    output logic      clear,
    output logic      sc_fail,
    output logic      stall,
    output logic      rsp_fault
);

    enum logic [1:0] {st_idle, st_read, st_write, st_done} state;

    req_id_t last_id;
    logic    last_vld;      // nothing completed yet after reset
    addr_t   resv_addr;
    logic    resv_vld;

    logic start;
    logic is_lr;
    logic is_sc;
    logic is_amo;
    logic sc_hit;
    logic busy;

    assign start  = req_valid && req_kind != kind_none && (!last_vld || req_id != last_id);
    assign is_lr  = req_kind == kind_atomic && req_func.atomic == amo_lr;
    assign is_sc  = req_kind == kind_atomic && req_func.atomic == amo_sc;
    assign is_amo = req_kind == kind_atomic && !is_lr && !is_sc;
    assign sc_hit = resv_vld && resv_addr == req_addr;
    assign busy   = state == st_read || state == st_write;

    assign stall   = busy || (state == st_idle && start);
    assign capture = state == st_read && ack;
    assign clear   = busy && expired;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cyc       <= 1'b0;
            stb       <= 1'b0;
            we        <= 1'b0;
            sc_fail   <= 1'b0;
            rsp_fault <= 1'b0;
            last_id   <= '0;
            last_vld  <= 1'b0;
            resv_addr <= '0;
            resv_vld  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        rsp_fault <= 1'b0;
                        if (is_sc) begin
                            resv_vld <= 1'b0;   // every SC drops the reservation
                            sc_fail  <= !sc_hit;
                            if (sc_hit) begin
                                state <= st_write;
                                cyc   <= 1'b1;
                                stb   <= 1'b1;
                                we    <= 1'b1;
                            end else begin
                                // no bus cycle for a failed SC
                                state    <= st_done;
                                last_id  <= req_id;
                                last_vld <= 1'b1;
                            end
                        end else begin
                            if (is_lr) begin
                                resv_addr <= req_addr;
                                resv_vld  <= 1'b1;
                            end
                            state <= (req_kind == kind_store) ? st_write : st_read;
                            cyc   <= 1'b1;
                            stb   <= 1'b1;
                            we    <= req_kind == kind_store;
                        end
                    end
                end
                st_read, st_write: begin
                    if (expired) begin
                        cyc       <= 1'b0;
                        stb       <= 1'b0;
                        we        <= 1'b0;
                        rsp_fault <= 1'b1;
                        state     <= st_done;
                        last_id   <= req_id;
                        last_vld  <= 1'b1;
                    end else if (!stb) begin
                        stb <= 1'b1;            // write half of an AMO
                    end else if (ack) begin
                        stb <= 1'b0;
                        if (state == st_read && is_amo) begin
                            state <= st_write;  // keep cyc for the write
                            we    <= 1'b1;
                        end else begin
                            cyc      <= 1'b0;
                            we       <= 1'b0;
                            state    <= st_done;
                            last_id  <= req_id;
                            last_vld <= 1'b1;
                        end
                    end
                end
                default: state <= st_idle;      // st_done, completion cycle
            endcase
        end
    end

endmodule

// ==== source/mem_stage_pkg.sv ====
package mem_stage_pkg;

    localparam int xlen = 32;
    localparam int sel_w = xlen / 8;

    typedef logic [xlen-1:0] data_t;
    typedef logic [31:0]     addr_t;
    typedef logic [3:0]      req_id_t;

    typedef enum logic [1:0] {
        kind_none,
        kind_load,
        kind_store,
        kind_atomic
    } mem_kind_e;

    typedef enum logic [1:0] {
        size_b,
        size_h,
        size_w
    } mem_size_e;

    typedef enum logic [3:0] {
        amo_lr,
        amo_sc,
        amo_swap,
        amo_add,
        amo_xor,
        amo_and,
        amo_or,
        amo_min,
        amo_max,
        amo_minu,
        amo_maxu
    } amo_op_e;

    // same 4 bits, read by kind
    typedef union packed {
        struct packed {
            logic      zext;
            mem_size_e size;
            logic      spare;
        } plain;                // load / store
        amo_op_e atomic;        // kind_atomic
    } mem_func_u;

    localparam int ram_words   = 256;
    localparam int ram_bytes   = ram_words * 4;  // first unmapped address
    localparam int ram_aw      = $clog2(ram_words);
    localparam int ram_wait    = 2;
    localparam int wait_w      = $clog2(ram_wait) + 1;
    localparam int bus_timeout = 16;
    localparam int timer_w     = $clog2(bus_timeout);

endpackage
